// ==== logic/core_types_pkg.sv ====
`default_nettype none

package core_types_pkg;

    // reorder buffer tag width, one tag per in-flight instruction
    localparam int ROB_ID_W = 6;

    // register data width
    localparam int XLEN = 32;

    typedef logic [ROB_ID_W-1:0] rob_id_t;
    typedef logic [XLEN-1:0]     reg_data_t;

    // result broadcast seen by every waiting source operand
    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id; // tag of the producing instruction
        reg_data_t data;
    } bcast_t;

endpackage

`default_nettype wire

// ==== logic/iq_pkg.sv ====
`default_nettype none

package iq_pkg;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SRA = 3'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        EMPTY   = 2'd0,
        WAITING = 2'd1, // holds at least one source still in flight
        READY   = 2'd2
    } slot_state_e;

    typedef struct packed {
        logic                       used; // operand is read by the op
        logic                       rdy;  // data field holds the value
        core_types_pkg::rob_id_t    tag;
        core_types_pkg::reg_data_t  data;
    } src_t;

    typedef struct packed {
        alu_op_e                 op;
        core_types_pkg::rob_id_t dst_rob_id;
        src_t                    src1;
        src_t                    src2;
    } iq_entry_t;

    typedef struct packed {
        alu_op_e                   op;
        core_types_pkg::rob_id_t   dst_rob_id;
        core_types_pkg::reg_data_t src1_data;
        core_types_pkg::reg_data_t src2_data;
    } iq_issue_t;

    // tag match against both broadcast ports, alu result has priority
    function automatic src_t capture_src(src_t src, core_types_pkg::bcast_t alu_bc,
                                         core_types_pkg::bcast_t ld_bc);
        src_t res;
        res = src;
        if (src.used && !src.rdy) begin
            if (alu_bc.valid && alu_bc.rob_id == src.tag) begin
                res.rdy  = 1'b1;
                res.data = alu_bc.data;
            end else if (ld_bc.valid && ld_bc.rob_id == src.tag) begin
                res.rdy  = 1'b1;
                res.data = ld_bc.data;
            end
        end
        return res;
    endfunction

    // an unused operand never blocks issue
    function automatic logic src_ok(src_t src);
        return !src.used || src.rdy;
    endfunction

endpackage

`default_nettype wire

// ==== logic/iq_alloc.sv ====
`timescale 1ns/1ns
`default_nettype none

module iq_alloc #(
    parameter int IQ_DEPTH = 8,
    parameter int SEQ_W    = 4
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          flush,

    input  wire                          dispatch_valid,
    input  wire iq_pkg::iq_entry_t       dispatch_entry,

    input  wire core_types_pkg::bcast_t  alu_bcast,
    input  wire core_types_pkg::bcast_t  ld_bcast,

    input  wire [IQ_DEPTH-1:0]           slot_free,

    output logic [IQ_DEPTH-1:0]          slot_wr,
    output iq_pkg::iq_entry_t            wr_entry,
    output logic [SEQ_W-1:0]             wr_seq,
    output logic [SEQ_W-1:0]             next_seq
);

    logic [IQ_DEPTH-1:0] lowest_free;
    logic                accept;
    logic [SEQ_W-1:0]    seq_q;

    // isolate the lowest set bit of the free vector
    assign lowest_free = slot_free & (~slot_free + 1'b1);

    // credits make a free slot certain, the check only guards a misbehaving sender
    assign accept  = dispatch_valid && !flush && (|slot_free);
    assign slot_wr = accept ? lowest_free : '0;

    // a result broadcast in the write cycle would otherwise be missed by the new slot
    always_comb begin
        wr_entry      = dispatch_entry;
        wr_entry.src1 = iq_pkg::capture_src(dispatch_entry.src1, alu_bcast, ld_bcast);
        wr_entry.src2 = iq_pkg::capture_src(dispatch_entry.src2, alu_bcast, ld_bcast);
    end

    // age stamp, wraps at twice the depth so distances stay unambiguous
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            seq_q <= '0;
        end else if (accept) begin
            seq_q <= seq_q + 1'b1;
        end
    end

    assign wr_seq   = seq_q;  // stamp for this cycle's dispatch
    assign next_seq = seq_q;  // reference point for age ranking

endmodule

`default_nettype wire

// ==== logic/iq_slot.sv ====
`timescale 1ns/1ns
`default_nettype none

module iq_slot #(
    parameter int SEQ_W = 4
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          flush,

    input  wire                          wr,
    input  wire iq_pkg::iq_entry_t       wr_entry,
    input  wire [SEQ_W-1:0]              wr_seq,

    input  wire core_types_pkg::bcast_t  alu_bcast,
    input  wire core_types_pkg::bcast_t  ld_bcast,

    input  wire                          grant,

    output logic                         free,
    output logic                         ready,
    output iq_pkg::iq_entry_t            entry,
    output logic [SEQ_W-1:0]             seq
);

    iq_pkg::slot_state_e state_q;
    iq_pkg::iq_entry_t   entry_q;
    iq_pkg::iq_entry_t   entry_cap;
    logic [SEQ_W-1:0]    seq_q;
    logic                wr_ok;
    logic                cap_ok;

    // incoming entry already went through same-cycle capture in the allocator
    assign wr_ok = iq_pkg::src_ok(wr_entry.src1) && iq_pkg::src_ok(wr_entry.src2);

    // wakeup from either broadcast port
    always_comb begin
        entry_cap      = entry_q;
        entry_cap.src1 = iq_pkg::capture_src(entry_q.src1, alu_bcast, ld_bcast);
        entry_cap.src2 = iq_pkg::capture_src(entry_q.src2, alu_bcast, ld_bcast);
        cap_ok         = iq_pkg::src_ok(entry_cap.src1) && iq_pkg::src_ok(entry_cap.src2);
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            state_q <= iq_pkg::EMPTY;
        end else begin
            case (state_q)
                iq_pkg::EMPTY: begin
                    if (wr) begin
                        state_q <= wr_ok ? iq_pkg::READY : iq_pkg::WAITING;
                    end
                end
                iq_pkg::WAITING: begin
                    if (cap_ok) begin
                        state_q <= iq_pkg::READY;
                    end
                end
                iq_pkg::READY: begin
                    if (grant) begin
                        state_q <= iq_pkg::EMPTY; // selector took it
                    end
                end
                default: state_q <= iq_pkg::EMPTY;
            endcase
        end
    end

    // payload, only meaningful while the slot is occupied
    always_ff @(posedge clk) begin
        if (wr) begin
            entry_q <= wr_entry;
            seq_q   <= wr_seq;
        end else if (state_q == iq_pkg::WAITING) begin
            entry_q <= entry_cap;
        end
    end

    assign free  = (state_q == iq_pkg::EMPTY);
    assign ready = (state_q == iq_pkg::READY);
    assign entry = entry_q;
    assign seq   = seq_q;

endmodule

`default_nettype wire

// ==== logic/iq_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module iq_select #(
    parameter int IQ_DEPTH = 8,
    parameter int SEQ_W    = 4
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   flush,

    input  wire [IQ_DEPTH-1:0]                    slot_ready,
    input  wire iq_pkg::iq_entry_t [IQ_DEPTH-1:0] slot_entries,
    input  wire [IQ_DEPTH-1:0][SEQ_W-1:0]         slot_seq,
    input  wire [SEQ_W-1:0]                       next_seq,

    output logic [IQ_DEPTH-1:0]                   grant,

    output logic                                  issue_valid,
    output iq_pkg::iq_issue_t                     issue,

    output logic                                  credit_return
);

    localparam int IDX_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

    logic [SEQ_W-1:0]  best_age;
    logic [IDX_W-1:0]  best_idx;
    logic              found;
    iq_pkg::iq_entry_t pick;

    // oldest ready slot has the largest distance back from next_seq
    always_comb begin
        logic [SEQ_W-1:0] age;
        best_age = '0;
        best_idx = '0;
        found    = 1'b0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            age = next_seq - slot_seq[i]; // live stamps give 1..IQ_DEPTH
            if (slot_ready[i] && age > best_age) begin
                best_age = age;
                best_idx = IDX_W'(i);
                found    = 1'b1;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found && !flush) begin
            grant[best_idx] = 1'b1;
        end
    end

    assign pick = slot_entries[best_idx];

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= |grant;
        end
    end

    always_ff @(posedge clk) begin
        if (|grant) begin
            issue <= '{op:         pick.op,
                       dst_rob_id: pick.dst_rob_id,
                       src1_data:  pick.src1.data,
                       src2_data:  pick.src2.data};
        end
    end

    // each issue frees exactly one slot, so the credit rides with issue_valid
    assign credit_return = issue_valid;

endmodule

`default_nettype wire

// ==== logic/int_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module int_alu (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          flush,

    input  wire                          issue_valid,
    input  wire iq_pkg::iq_issue_t       issue,

    output core_types_pkg::bcast_t       alu_bcast
);

    core_types_pkg::reg_data_t a;
    core_types_pkg::reg_data_t b;
    core_types_pkg::reg_data_t res;
    logic [4:0]                shamt;

    logic                      valid_q;
    core_types_pkg::rob_id_t   rob_id_q;
    core_types_pkg::reg_data_t data_q;

    assign a     = issue.src1_data;
    assign b     = issue.src2_data;
    assign shamt = b[4:0]; // shifts only look at the low bits

    always_comb begin
        case (issue.op)
            iq_pkg::ADD: res = a + b;
            iq_pkg::SUB: res = a - b;
            iq_pkg::AND: res = a & b;
            iq_pkg::OR:  res = a | b;
            iq_pkg::XOR: res = a ^ b;
            iq_pkg::SLL: res = a << shamt;
            iq_pkg::SRL: res = a >> shamt;
            iq_pkg::SRA: res = $signed(a) >>> shamt; // sign fill
            default:     res = a + b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            rob_id_q <= issue.dst_rob_id;
            data_q   <= res;
        end
    end

    assign alu_bcast = '{valid: valid_q, rob_id: rob_id_q, data: data_q};

endmodule

`default_nettype wire

// ==== logic/issue_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_unit #(
    parameter int IQ_DEPTH = 8
) (
    input  wire                           clk,
    input  wire                           rst_n,

    input  wire                           dispatch_valid,
    input  wire iq_pkg::iq_entry_t        dispatch_entry,
    output wire                           credit_return,

    input  wire core_types_pkg::bcast_t   ld_bcast,

    input  wire                           flush, // mispredict redirect

    output wire                           issue_valid,
    output wire core_types_pkg::rob_id_t  issue_rob_id,

    output wire core_types_pkg::bcast_t   result
);

    // one extra bit so that age distances never alias
    localparam int SEQ_W = $clog2(IQ_DEPTH) + 1;

    wire [IQ_DEPTH-1:0]                    slot_free;
    wire [IQ_DEPTH-1:0]                    slot_ready;
    wire [IQ_DEPTH-1:0]                    slot_wr;
    wire [IQ_DEPTH-1:0]                    slot_grant;
    wire iq_pkg::iq_entry_t [IQ_DEPTH-1:0] slot_entries;
    wire [IQ_DEPTH-1:0][SEQ_W-1:0]         slot_seq;

    wire iq_pkg::iq_entry_t                wr_entry;
    wire [SEQ_W-1:0]                       wr_seq;
    wire [SEQ_W-1:0]                       next_seq;
    wire iq_pkg::iq_issue_t                issue;
    wire core_types_pkg::bcast_t           alu_bcast;

    iq_alloc #(
        .IQ_DEPTH (IQ_DEPTH),
        .SEQ_W    (SEQ_W)
    ) u_alloc (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_entry (dispatch_entry),
        .alu_bcast      (alu_bcast),
        .ld_bcast       (ld_bcast),
        .slot_free      (slot_free),
        .slot_wr        (slot_wr),
        .wr_entry       (wr_entry),
        .wr_seq         (wr_seq),
        .next_seq       (next_seq)
    );

    for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_slot
        iq_slot #(
            .SEQ_W (SEQ_W)
        ) u_slot (
            .clk       (clk),
            .rst_n     (rst_n),
            .flush     (flush),
            .wr        (slot_wr[i]),
            .wr_entry  (wr_entry),
            .wr_seq    (wr_seq),
            .alu_bcast (alu_bcast),
            .ld_bcast  (ld_bcast),
            .grant     (slot_grant[i]),
            .free      (slot_free[i]),
            .ready     (slot_ready[i]),
            .entry     (slot_entries[i]),
            .seq       (slot_seq[i])
        );
    end

    iq_select #(
        .IQ_DEPTH (IQ_DEPTH),
        .SEQ_W    (SEQ_W)
    ) u_select (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .slot_ready    (slot_ready),
        .slot_entries  (slot_entries),
        .slot_seq      (slot_seq),
        .next_seq      (next_seq),
        .grant         (slot_grant),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .credit_return (credit_return)
    );

    int_alu u_alu (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .alu_bcast   (alu_bcast)
    );

    assign issue_rob_id = issue.dst_rob_id;
    assign result       = alu_bcast; // also leaves toward writeback

endmodule

`default_nettype wire

// ==== tests/issue_unit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_unit_tb;

    localparam int IQ_DEPTH = 8;
    localparam string STIM_PATH = "tests/issue_stim.txt";

    logic                        clk;
    logic                        rst_n;
    logic                        dispatch_valid;
    iq_pkg::iq_entry_t           dispatch_entry;
    logic                        credit_return;
    core_types_pkg::bcast_t      ld_bcast;
    logic                        flush;
    logic                        issue_valid;
    core_types_pkg::rob_id_t     issue_rob_id;
    core_types_pkg::bcast_t      result;

    // scoreboard, indexed by destination tag
    bit                          live [64];
    bit                          issued [64];
    bit                          done [64];
    iq_pkg::alu_op_e             sb_op [64];
    iq_pkg::src_t                sb_src1 [64];
    iq_pkg::src_t                sb_src2 [64];
    logic [31:0]                 exp_res [64];
    logic [31:0]                 got_res [64];
    bit                          known [64]; // value seen on result or load port
    logic [31:0]                 known_val [64];

    int                          credits;
    int                          issue_cnt;
    int                          credit_cnt;
    logic [5:0]                  issue_log [$];
    logic [7:0]                  lfsr;
    bit                          ld_pending; // load held into the next dispatch cycle
    int                          cycles;
    int                          cycle_limit;

    issue_unit #(
        .IQ_DEPTH (IQ_DEPTH)
    ) i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_entry (dispatch_entry),
        .credit_return  (credit_return),
        .ld_bcast       (ld_bcast),
        .flush          (flush),
        .issue_valid    (issue_valid),
        .issue_rob_id   (issue_rob_id),
        .result         (result)
    );

    always #4 clk = ~clk;

    task automatic fail_msg(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    // reference ALU, SRA done by shifting a sign extended copy
    function automatic logic [31:0] alu_model(iq_pkg::alu_op_e op, logic [31:0] a,
                                              logic [31:0] b);
        logic [63:0] wide;
        wide = {{32{a[31]}}, a} >> b[4:0];
        case (op)
            iq_pkg::ADD: return a + b;
            iq_pkg::SUB: return a - b;
            iq_pkg::AND: return a & b;
            iq_pkg::OR:  return a | b;
            iq_pkg::XOR: return a ^ b;
            iq_pkg::SLL: return a << b[4:0];
            iq_pkg::SRL: return a >> b[4:0];
            default:     return wide[31:0];
        endcase
    endfunction

    function automatic bit src_known(iq_pkg::src_t s);
        return !s.used || s.rdy || known[s.tag];
    endfunction

    function automatic logic [31:0] src_value(iq_pkg::src_t s);
        if (!s.used || s.rdy) begin
            return s.data;
        end
        return known_val[s.tag];
    endfunction

    // a value broadcast in an earlier cycle is handed over as ready, as rename does
    function automatic iq_pkg::src_t rename_src(iq_pkg::src_t s);
        iq_pkg::src_t r;
        r = s;
        if (s.used && !s.rdy && known[s.tag]) begin
            r.rdy  = 1'b1;
            r.data = known_val[s.tag];
        end
        return r;
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val  = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 8'hB8) : (lfsr >> 1);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // outputs sampled mid cycle, away from the clock edge
    task automatic observe();
        logic [5:0] t;
        if (issue_valid) begin
            t = issue_rob_id;
            if (!live[t] || issued[t]) begin
                fail_msg($sformatf("tag %h issued while not waiting in the queue", t));
            end
            if (!src_known(sb_src1[t]) || !src_known(sb_src2[t])) begin
                fail_msg($sformatf("tag %h issued before its sources were known", t));
            end
            exp_res[t] = alu_model(sb_op[t], src_value(sb_src1[t]), src_value(sb_src2[t]));
            issued[t]  = 1'b1;
            issue_cnt++;
            issue_log.push_back(t);
        end
        if (result.valid) begin
            t = result.rob_id;
            if (!live[t] || !issued[t] || done[t]) begin
                fail_msg($sformatf("unexpected result for tag %h", t));
            end
            check($sformatf("alu result tag %h", t), exp_res[t], result.data);
            done[t]      = 1'b1;
            got_res[t]   = result.data;
            known[t]     = 1'b1;
            known_val[t] = result.data;
        end
        if (credit_return) begin
            credits++;
            credit_cnt++;
        end
        if (ld_bcast.valid) begin
            known[ld_bcast.rob_id]     = 1'b1;
            known_val[ld_bcast.rob_id] = ld_bcast.data;
        end
        if (flush) begin
            for (int i = 0; i < 64; i++) begin
                if (live[i] && !done[i]) begin
                    live[i] = 1'b0; // killed, must stay silent from now on
                end
            end
            credits = IQ_DEPTH;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            observe();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the queue stopped making progress", cycles);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic do_dispatch(input logic [31:0] f [10]);
        iq_pkg::iq_entry_t e;
        int idle;
        if (!ld_pending) begin
            take_bits(2, idle);
            repeat (idle) step();
        end
        while (credits == 0) begin
            step();
        end
        e.op         = iq_pkg::alu_op_e'(f[0][2:0]);
        e.dst_rob_id = f[1][5:0];
        e.src1       = '{used: f[2][0], rdy: f[3][0], tag: f[4][5:0], data: f[5]};
        e.src2       = '{used: f[6][0], rdy: f[7][0], tag: f[8][5:0], data: f[9]};
        e.src1       = rename_src(e.src1);
        e.src2       = rename_src(e.src2);
        live[e.dst_rob_id]    = 1'b1;
        issued[e.dst_rob_id]  = 1'b0;
        done[e.dst_rob_id]    = 1'b0;
        known[e.dst_rob_id]   = 1'b0;
        sb_op[e.dst_rob_id]   = e.op;
        sb_src1[e.dst_rob_id] = e.src1;
        sb_src2[e.dst_rob_id] = e.src2;
        credits--;
        dispatch_entry = e;
        dispatch_valid = 1'b1;
        step();
        dispatch_valid = 1'b0;
        if (ld_pending) begin
            ld_bcast   = '0;
            ld_pending = 1'b0;
        end
    endtask

    task automatic drained_check();
        check("credit count", IQ_DEPTH, credits);
        check("credit pulses", issue_cnt, credit_cnt);
        for (int i = 0; i < 64; i++) begin
            if (live[i] && (!issued[i] || !done[i])) begin
                fail_msg($sformatf("tag %h never completed", i));
            end
        end
    endtask

    initial begin
        int          fd;
        int          code;
        int          lines;
        int          n;
        logic [7:0]  cmd;
        logic [31:0] f [10];
        logic [31:0] tag;
        logic [31:0] val;
        string       line;

        clk            = 1'b0;
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_entry = '0;
        ld_bcast       = '0;
        flush          = 1'b0;
        credits        = IQ_DEPTH;
        issue_cnt      = 0;
        credit_cnt     = 0;
        lfsr           = 8'd46;
        ld_pending     = 1'b0;
        cycles         = 0;
        cycle_limit    = 1000;

        fd = $fopen(STIM_PATH, "r");
        if (fd == 0) begin
            fail_msg("cannot open the stimulus file");
        end
        lines = 0;
        while (!$feof(fd)) begin
            void'($fgets(line, fd));
            lines++;
        end
        $fclose(fd);
        cycle_limit = 20 * lines + 200;
        fd = $fopen(STIM_PATH, "r");

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        code = $fscanf(fd, " %c", cmd);
        while (code == 1) begin
            case (cmd)
                "#": void'($fgets(line, fd));
                "D": begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                                   f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                    do_dispatch(f);
                end
                "L", "M": begin
                    code = $fscanf(fd, "%h %h", tag, val);
                    ld_bcast = '{valid: 1'b1, rob_id: tag[5:0], data: val};
                    if (cmd == "M") begin
                        ld_pending = 1'b1;
                    end else begin
                        step();
                        ld_bcast = '0;
                    end
                end
                "F": begin
                    flush = 1'b1;
                    step();
                    flush = 1'b0;
                end
                "W": begin
                    code = $fscanf(fd, "%d", n);
                    repeat (n) step();
                end
                "E": begin
                    code = $fscanf(fd, "%h %h", tag, val);
                    if (!done[tag[5:0]]) begin
                        fail_msg($sformatf("no result arrived for tag %h", tag[5:0]));
                    end
                    check($sformatf("stim result tag %h", tag[5:0]), val, got_res[tag[5:0]]);
                end
                "R": issue_log.delete();
                "K": begin
                    code = $fscanf(fd, "%h", tag);
                    if (issue_log.size() == 0) begin
                        fail_msg($sformatf("tag %h was expected to issue but did not", tag));
                    end
                    check("issue order", tag, 32'(issue_log.pop_front()));
                end
                "C": drained_check();
                default: fail_msg($sformatf("unknown stimulus command %c", cmd));
            endcase
            code = $fscanf(fd, " %c", cmd);
        end
        $fclose(fd);

        repeat (10) step();
        drained_check();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/issue_stim.txt ====
# D op dst used1 rdy1 tag1 data1 used2 rdy2 tag2 data2 | L tag data | M tag data (same cycle as next D)
# F flush | W cycles | E tag result | R clear issue log | K tag issues next | C drained check
D 0 01 1 1 00 00000005 1 1 00 00000007
D 1 02 1 0 01 00000000 1 1 00 00000002
D 5 03 1 0 02 00000000 1 1 00 00000004
D 7 04 1 1 00 80000000 1 1 00 00000024
D 4 05 1 0 03 00000000 1 0 01 00000000
D 2 06 1 0 20 00000000 1 1 00 0000ffff
D 3 07 1 0 20 00000000 1 0 06 00000000
D 0 08 1 1 00 00000003 0 0 00 00000000
L 20 12345678
W 20
E 01 0000000c
E 02 0000000a
E 03 000000a0
E 04 f8000000
E 05 000000ac
E 06 00005678
E 07 12345678
E 08 00000003
C
R
D 0 10 1 0 21 00000000 1 1 00 00000001
D 1 11 1 0 21 00000000 1 1 00 00000002
D 0 12 1 0 21 00000000 1 1 00 00000003
D 4 13 1 0 21 00000000 1 1 00 00000004
D 0 14 1 0 21 00000000 1 1 00 00000005
D 6 15 1 0 21 00000000 1 1 00 00000006
D 0 16 1 0 21 00000000 1 1 00 00000007
D 3 17 1 0 21 00000000 1 1 00 00000008
L 21 00000100
W 20
K 10
K 11
K 12
K 13
K 14
K 15
K 16
K 17
E 11 000000fe
C
D 0 18 1 0 22 00000000 1 1 00 00000001
D 0 19 1 1 00 00000005 1 1 00 00000006
F
L 22 00000009
D 0 1a 1 1 00 00000002 1 1 00 00000003
W 10
E 1a 00000005
C
M 23 00000040
D 0 1b 1 0 23 00000000 1 1 00 00000001
W 10
E 1b 00000041
C

// ==== sources.f ====
logic/core_types_pkg.sv
logic/iq_pkg.sv
logic/iq_alloc.sv
logic/iq_slot.sv
logic/iq_select.sv
logic/int_alu.sv
logic/issue_unit.sv
tests/issue_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the issue unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing \
    -Wno-fatal \
    -f sources.f \
    --top-module issue_unit_tb \
    -o issue_unit_sim

# a $fatal in the testbench gives a nonzero exit status
./obj_dir/issue_unit_sim

echo "simulation finished"
